/* common/ibuffer_pkg.sv */
package ibuffer_pkg;

    // --------------------------------------------------
    // sizes

    // queue depth, need not be a power of two
    localparam int IBUFFER_ENTRIES = 8;

    // outstanding fetch misses
    localparam int FMID_COUNT = 4;

    // 16-byte aligned block address
    localparam int BLOCK_PC_BITS = 28;

    localparam int IB_IDX_BITS = $clog2(IBUFFER_ENTRIES);
    localparam int FMID_BITS = $clog2(FMID_COUNT);
    localparam int FETCH_BLOCK_BITS = 128;

    // --------------------------------------------------
    // vector types

    // entry index into the queue
    typedef logic [IB_IDX_BITS-1:0] ib_idx_t;

    // fetch-miss id
    typedef logic [FMID_BITS-1:0] fmid_t;

    // one fetch block of 16 bytes
    typedef logic [FETCH_BLOCK_BITS-1:0] fetch16b_t;

    // block pc
    typedef logic [BLOCK_PC_BITS-1:0] block_pc_t;

endpackage

/* common/ibuffer_store_if.sv */
`timescale 1ns/1ns

interface ibuffer_store_if;

    // pc array write
    logic                   pc_wen;
    ibuffer_pkg::ib_idx_t   pc_windex;
    ibuffer_pkg::block_pc_t pc_wdata;

    // instr array write, shared by hit and fill
    logic                   instr_wen;
    ibuffer_pkg::ib_idx_t   instr_windex;
    ibuffer_pkg::fetch16b_t instr_wdata;

    // head read
    ibuffer_pkg::ib_idx_t   rindex;
    ibuffer_pkg::block_pc_t pc_rdata;
    ibuffer_pkg::fetch16b_t instr_rdata;

    modport ctrl (
        output pc_wen, pc_windex, pc_wdata,
        output instr_wen, instr_windex, instr_wdata,
        output rindex,
        input  pc_rdata, instr_rdata
    );

    modport store (
        input  pc_wen, pc_windex, pc_wdata,
        input  instr_wen, instr_windex, instr_wdata,
        input  rindex,
        output pc_rdata, instr_rdata
    );

endinterface

/* design/fmid_tracker.sv */
`timescale 1ns/1ns

module fmid_tracker (
    input  logic               CLK,
    input  logic               nRST,

    // allocation
    input  logic               alloc,
    output logic               new_ready,
    output ibuffer_pkg::fmid_t new_id,

    // release on miss return
    input  logic               release_valid,
    input  ibuffer_pkg::fmid_t release_id
);

    // one busy bit per id
    logic [ibuffer_pkg::FMID_COUNT-1:0] busy;

    // --------------------------------------------------
    // lowest free id

    always_comb begin
        new_id = '0;
        // scan downward so the lowest index wins
        for (int i = ibuffer_pkg::FMID_COUNT - 1; i >= 0; i--) begin
            if (~busy[i]) begin
                new_id = ibuffer_pkg::fmid_t'(i);
            end
        end
    end

    assign new_ready = ~&busy;

    // --------------------------------------------------
    // busy bits

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            busy <= '0;
        end else begin
            if (alloc) begin
                busy[new_id] <= 1'b1;
            end
            // release last, so it wins on the same id
            if (release_valid) begin
                busy[release_id] <= 1'b0;
            end
        end
    end

endmodule

/* ibuffer/ibuffer_store.sv */
`timescale 1ns/1ns

module ibuffer_store (
    input  logic           CLK,
    ibuffer_store_if.store store
);

    // --------------------------------------------------
    // arrays

    // block pc per entry
    ibuffer_pkg::block_pc_t pc_mem [ibuffer_pkg::IBUFFER_ENTRIES];

    // 16-byte block per entry
    ibuffer_pkg::fetch16b_t instr_mem [ibuffer_pkg::IBUFFER_ENTRIES];

    // --------------------------------------------------
    // write ports

    always_ff @(posedge CLK) begin
        if (store.pc_wen) begin
            pc_mem[store.pc_windex] <= store.pc_wdata;
        end
    end

    // hit data or miss fill, never both
    always_ff @(posedge CLK) begin
        if (store.instr_wen) begin
            instr_mem[store.instr_windex] <= store.instr_wdata;
        end
    end

    // --------------------------------------------------
    // read ports, async at head

    assign store.pc_rdata = pc_mem[store.rindex];
    assign store.instr_rdata = instr_mem[store.rindex];

endmodule

/* ibuffer/ibuffer_ctrl.sv */
`timescale 1ns/1ns

module ibuffer_ctrl (
    input  logic                   CLK,
    input  logic                   nRST,

    // enqueue from cache
    input  logic                   enq_valid,
    input  logic                   enq_hit,
    input  ibuffer_pkg::block_pc_t enq_pc,
    input  ibuffer_pkg::fetch16b_t enq_block,
    output logic                   enq_ready,
    output ibuffer_pkg::fmid_t     enq_fmid,

    // miss return
    input  logic                   miss_return_valid,
    input  ibuffer_pkg::fmid_t     miss_return_fmid,
    input  ibuffer_pkg::fetch16b_t miss_return_block,

    // dequeue to decoder
    output logic                   deq_valid,
    input  logic                   deq_ready,

    input  logic                   restart,

    ibuffer_store_if.ctrl          store,

    // fmid tracker
    output logic                   alloc,
    input  logic                   new_ready,
    input  ibuffer_pkg::fmid_t     new_id,
    output logic                   release_valid,
    output ibuffer_pkg::fmid_t     release_id
);

    // --------------------------------------------------
    // pointers and flags

    ibuffer_pkg::ib_idx_t enq_ptr, enq_ptr_next;
    ibuffer_pkg::ib_idx_t deq_ptr, deq_ptr_next;
    logic                 not_full;
    logic                 not_empty;
    logic                 enq_fire;
    logic                 deq_fire;

    // per entry miss state
    logic [ibuffer_pkg::IBUFFER_ENTRIES-1:0] waiting;
    ibuffer_pkg::fmid_t                      fmid_by_entry [ibuffer_pkg::IBUFFER_ENTRIES];
    logic [ibuffer_pkg::IBUFFER_ENTRIES-1:0] fill_vec;
    logic                                    fill_valid;
    ibuffer_pkg::ib_idx_t                    fill_idx;

    // wrap by compare, works for any depth
    function automatic ibuffer_pkg::ib_idx_t next_idx(input ibuffer_pkg::ib_idx_t idx);
        if (idx == ibuffer_pkg::ib_idx_t'(ibuffer_pkg::IBUFFER_ENTRIES - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign enq_ptr_next = next_idx(enq_ptr);
    assign deq_ptr_next = next_idx(deq_ptr);

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
            not_full <= 1'b1;
            not_empty <= 1'b0;
        end else if (restart) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
            not_full <= 1'b1;
            not_empty <= 1'b0;
        end else begin
            if (enq_fire) begin
                enq_ptr <= enq_ptr_next;
            end
            if (deq_fire) begin
                deq_ptr <= deq_ptr_next;
            end
            if (enq_fire & ~deq_fire) begin
                not_full <= enq_ptr_next != deq_ptr;
                not_empty <= 1'b1;
            end
            if (deq_fire & ~enq_fire) begin
                not_full <= 1'b1;
                not_empty <= deq_ptr_next != enq_ptr;
            end
        end
    end

    // --------------------------------------------------
    // miss fill match

    always_comb begin
        fill_idx = '0;
        for (int i = 0; i < ibuffer_pkg::IBUFFER_ENTRIES; i++) begin
            fill_vec[i] = miss_return_valid & waiting[i]
                & (fmid_by_entry[i] == miss_return_fmid);
            // one-hot to index
            if (fill_vec[i]) begin
                fill_idx = fill_idx | ibuffer_pkg::ib_idx_t'(i);
            end
        end
        fill_valid = |fill_vec;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            waiting <= '0;
        end else if (restart) begin
            waiting <= '0;
        end else begin
            waiting <= waiting & ~fill_vec;
            if (enq_fire) begin
                waiting[enq_ptr] <= ~enq_hit;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            fmid_by_entry[enq_ptr] <= new_id;
        end
    end

    // --------------------------------------------------
    // handshakes and storage ports

    // one instr write port: a fill this cycle blocks a hit
    assign enq_ready = not_full & ~restart
        & (~fill_valid | ~enq_hit)
        & (new_ready | enq_hit);
    assign enq_fmid = new_id;

    // head must be present and already filled
    assign deq_valid = not_empty & ~waiting[deq_ptr];

    assign store.pc_wen = enq_fire;
    assign store.pc_windex = enq_ptr;
    assign store.pc_wdata = enq_pc;

    assign store.instr_wen = fill_valid | (enq_fire & enq_hit);
    assign store.instr_windex = fill_valid ? fill_idx : enq_ptr;
    assign store.instr_wdata = fill_valid ? miss_return_block : enq_block;

    assign store.rindex = deq_ptr;

    // tracker
    assign alloc = enq_fire & ~enq_hit;
    assign release_valid = miss_return_valid;
    assign release_id = miss_return_fmid;

endmodule

/* design/ibuffer_top.sv */
`timescale 1ns/1ns

module ibuffer_top (
    input  logic                   CLK,
    input  logic                   nRST,

    // enqueue from cache
    input  logic                   enq_valid,
    input  logic                   enq_hit,
    input  ibuffer_pkg::block_pc_t enq_pc,
    input  ibuffer_pkg::fetch16b_t enq_block,
    output logic                   enq_ready,
    output ibuffer_pkg::fmid_t     enq_fmid,

    // miss return
    input  logic                   miss_return_valid,
    input  ibuffer_pkg::fmid_t     miss_return_fmid,
    input  ibuffer_pkg::fetch16b_t miss_return_block,

    // dequeue to decoder
    output logic                   deq_valid,
    output ibuffer_pkg::block_pc_t deq_pc,
    output ibuffer_pkg::fetch16b_t deq_block,
    input  logic                   deq_ready,

    input  logic                   restart
);

    // --------------------------------------------------
    // internal wiring

    ibuffer_store_if store_bus ();

    logic               alloc;
    logic               new_ready;
    ibuffer_pkg::fmid_t new_id;
    logic               release_valid;
    ibuffer_pkg::fmid_t release_id;

    // head entry straight from storage
    assign deq_pc = store_bus.pc_rdata;
    assign deq_block = store_bus.instr_rdata;

    // --------------------------------------------------
    // instances

    ibuffer_ctrl u_ctrl (
        .CLK               (CLK),
        .nRST              (nRST),
        .enq_valid         (enq_valid),
        .enq_hit           (enq_hit),
        .enq_pc            (enq_pc),
        .enq_block         (enq_block),
        .enq_ready         (enq_ready),
        .enq_fmid          (enq_fmid),
        .miss_return_valid (miss_return_valid),
        .miss_return_fmid  (miss_return_fmid),
        .miss_return_block (miss_return_block),
        .deq_valid         (deq_valid),
        .deq_ready         (deq_ready),
        .restart           (restart),
        .store             (store_bus.ctrl),
        .alloc             (alloc),
        .new_ready         (new_ready),
        .new_id            (new_id),
        .release_valid     (release_valid),
        .release_id        (release_id)
    );

    ibuffer_store u_store (
        .CLK   (CLK),
        .store (store_bus.store)
    );

    fmid_tracker u_fmid_tracker (
        .CLK           (CLK),
        .nRST          (nRST),
        .alloc         (alloc),
        .new_ready     (new_ready),
        .new_id        (new_id),
        .release_valid (release_valid),
        .release_id    (release_id)
    );

endmodule

/* sim/ibuffer_asserts.sv */
`timescale 1ns/1ns

module ibuffer_asserts (
    input logic                                    CLK,
    input logic                                    nRST,
    input logic                                    restart,
    input logic                                    deq_valid,
    input logic                                    deq_ready,
    input ibuffer_pkg::ib_idx_t                    deq_ptr,
    input logic [ibuffer_pkg::IBUFFER_ENTRIES-1:0] fill_vec
);

    // buffer is empty the cycle after a restart
    restart_empties: assert property (@(posedge CLK) disable iff (~nRST)
        restart |=> ~deq_valid)
        else $error("deq_valid high in the cycle after restart");

    // stalled head holds its place
    head_holds: assert property (@(posedge CLK) disable iff (~nRST)
        (deq_valid & ~deq_ready & ~restart) |=> (deq_valid & $stable(deq_ptr)))
        else $error("head dropped or moved under back-pressure");

    // single instr write port takes at most one fill entry
    one_fill_target: assert property (@(posedge CLK) disable iff (~nRST)
        $onehot0(fill_vec))
        else $error("miss return matches more than one waiting entry");

endmodule

bind ibuffer_ctrl ibuffer_asserts u_asserts (
    .CLK       (CLK),
    .nRST      (nRST),
    .restart   (restart),
    .deq_valid (deq_valid),
    .deq_ready (deq_ready),
    .deq_ptr   (deq_ptr),
    .fill_vec  (fill_vec)
);

/* sim/tb_ibuffer.sv */
`timescale 1ns/1ns

module tb_ibuffer;

    localparam int CLK_PERIOD   = 20;
    localparam int PHASE_CYCLES = 300;
    localparam int NUM_PHASES   = 7;
    localparam int TXN_COUNT    = PHASE_CYCLES * NUM_PHASES;

    logic                   CLK;
    logic                   nRST;
    logic                   enq_valid;
    logic                   enq_hit;
    ibuffer_pkg::block_pc_t enq_pc;
    ibuffer_pkg::fetch16b_t enq_block;
    logic                   enq_ready;
    ibuffer_pkg::fmid_t     enq_fmid;
    logic                   miss_return_valid;
    ibuffer_pkg::fmid_t     miss_return_fmid;
    ibuffer_pkg::fetch16b_t miss_return_block;
    logic                   deq_valid;
    ibuffer_pkg::block_pc_t deq_pc;
    ibuffer_pkg::fetch16b_t deq_block;
    logic                   deq_ready;
    logic                   restart;

    integer seed;

    // percentages per phase
    // hits, misses, back-pressure, id exhaustion, conflicts, restart, drain
    int enq_pct [NUM_PHASES] = '{70, 60, 80, 80, 80, 60, 0};
    int hit_pct [NUM_PHASES] = '{100, 50, 70, 20, 80, 50, 0};
    int ret_pct [NUM_PHASES] = '{0, 30, 20, 5, 60, 25, 60};
    int deq_pct [NUM_PHASES] = '{80, 70, 10, 60, 60, 60, 100};
    int rst_pct [NUM_PHASES] = '{0, 0, 0, 0, 0, 3, 0};

    // reference model with the head at index 0
    ibuffer_pkg::block_pc_t m_pc [$];
    ibuffer_pkg::fetch16b_t m_blk [$];
    logic                   m_wait [$];
    ibuffer_pkg::fmid_t     m_fmid [$];
    // ids handed out and not yet returned
    ibuffer_pkg::fmid_t     out_ids [$];

    ibuffer_top dut (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(TXN_COUNT * 40 * CLK_PERIOD);
        $display("Watchdog timeout: the test did not finish in time");
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

    // --------------------------------------------------
    // helpers

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic chance(input int percent);
        return ({$random(seed)} % 100) < percent;
    endfunction

    function automatic logic has_waiting(input ibuffer_pkg::fmid_t id);
        foreach (m_wait[i]) begin
            if (m_wait[i] && m_fmid[i] == id) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // tracker hands out the lowest id not in use
    function automatic ibuffer_pkg::fmid_t lowest_free_id();
        logic used;
        for (int id = 0; id < ibuffer_pkg::FMID_COUNT; id++) begin
            used = 1'b0;
            foreach (out_ids[i]) begin
                if (out_ids[i] == id) begin
                    used = 1'b1;
                end
            end
            if (!used) begin
                return ibuffer_pkg::fmid_t'(id);
            end
        end
        return '0;
    endfunction

    task automatic apply_return(input ibuffer_pkg::fmid_t id, input ibuffer_pkg::fetch16b_t data);
        foreach (m_wait[i]) begin
            if (m_wait[i] && m_fmid[i] == id) begin
                m_blk[i] = data;
                m_wait[i] = 1'b0;
            end
        end
        foreach (out_ids[i]) begin
            if (out_ids[i] == id) begin
                out_ids.delete(i);
                break;
            end
        end
    endtask

    // --------------------------------------------------
    // stimulus and checking

    initial begin
        logic exp_ready;
        logic exp_deq;
        ibuffer_pkg::fmid_t exp_fmid;

        seed = 26199;
        nRST = 1'b0;
        enq_valid = 1'b0;
        enq_hit = 1'b0;
        enq_pc = '0;
        enq_block = '0;
        miss_return_valid = 1'b0;
        miss_return_fmid = '0;
        miss_return_block = '0;
        deq_ready = 1'b0;
        restart = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        for (int phase = 0; phase < NUM_PHASES; phase++) begin
            for (int cyc = 0; cyc < PHASE_CYCLES; cyc++) begin
                @(negedge CLK);
                enq_valid = chance(enq_pct[phase]);
                enq_hit = chance(hit_pct[phase]);
                enq_pc = ibuffer_pkg::block_pc_t'($random(seed));
                enq_block = {$random(seed), $random(seed), $random(seed), $random(seed)};
                miss_return_valid = (out_ids.size() > 0) && chance(ret_pct[phase]);
                if (miss_return_valid) begin
                    miss_return_fmid = out_ids[{$random(seed)} % out_ids.size()];
                end
                miss_return_block = {$random(seed), $random(seed), $random(seed), $random(seed)};
                deq_ready = chance(deq_pct[phase]);
                restart = chance(rst_pct[phase]);
                #2;

                // expected outputs from the model state before this edge
                exp_ready = (m_pc.size() < ibuffer_pkg::IBUFFER_ENTRIES) && !restart
                    && !(enq_hit && miss_return_valid && has_waiting(miss_return_fmid))
                    && (enq_hit || out_ids.size() < ibuffer_pkg::FMID_COUNT);
                exp_fmid = lowest_free_id();
                exp_deq = (m_pc.size() > 0) && !m_wait[0];
                check_value("enq_ready", enq_ready, exp_ready);
                if (exp_ready && !enq_hit) begin
                    check_value("enq_fmid", enq_fmid, exp_fmid);
                end
                check_value("deq_valid", deq_valid, exp_deq);
                if (exp_deq) begin
                    check_value("deq_pc", deq_pc, m_pc[0]);
                    check_value("deq_block", deq_block, m_blk[0]);
                end

                // advance the model across the rising edge
                if (miss_return_valid) begin
                    apply_return(miss_return_fmid, miss_return_block);
                end
                if (restart) begin
                    m_pc.delete();
                    m_blk.delete();
                    m_wait.delete();
                    m_fmid.delete();
                end else begin
                    if (exp_deq && deq_ready) begin
                        void'(m_pc.pop_front());
                        void'(m_blk.pop_front());
                        void'(m_wait.pop_front());
                        void'(m_fmid.pop_front());
                    end
                    if (enq_valid && exp_ready) begin
                        m_pc.push_back(enq_pc);
                        m_blk.push_back(enq_hit ? enq_block : '0);
                        m_wait.push_back(!enq_hit);
                        m_fmid.push_back(exp_fmid);
                        if (!enq_hit) begin
                            out_ids.push_back(exp_fmid);
                        end
                    end
                end
            end
        end

        check_value("entries left after drain", m_pc.size(), 0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* src.f */
common/ibuffer_pkg.sv
common/ibuffer_store_if.sv
design/fmid_tracker.sv
ibuffer/ibuffer_store.sv
ibuffer/ibuffer_ctrl.sv
design/ibuffer_top.sv
sim/ibuffer_asserts.sv
sim/tb_ibuffer.sv

/* Bender.yml */
package:
  name: ibuffer

sources:
  - common/ibuffer_pkg.sv
  - common/ibuffer_store_if.sv
  - design/fmid_tracker.sv
  - ibuffer/ibuffer_store.sv
  - ibuffer/ibuffer_ctrl.sv
  - design/ibuffer_top.sv
  - target: simulation
    files:
      - sim/ibuffer_asserts.sv
      - sim/tb_ibuffer.sv
